//--- hdl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	// major opcodes kept by this core
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;

	// funct3 codes shared by OP and OP-IMM
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// selects sub and sra
	localparam logic [6:0] F7_ALT = 7'b0100000;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} alu_op_e;

endpackage

`default_nettype wire

//--- hdl/core_pkg.sv
`default_nettype none

package core_pkg;

	localparam int XLEN = 32;

	// defaults for the top level
	localparam int IN_DEPTH_DEF    = 4;
	localparam int RES_CREDITS_DEF = 2;

	typedef logic [4:0]      reg_idx_t;
	typedef logic [XLEN-1:0] word_t;
	typedef logic [31:0]     inst_t;

	// decode stage register
	typedef struct packed {
		logic                valid;
		rv_isa_pkg::alu_op_e alu_op;
		reg_idx_t            rd;
		word_t               op_a;
		word_t               op_b;
	} dec_uop_t;

	// execute output, also the bypass source
	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		word_t    value;
	} exec_fwd_t;

	// record sent downstream
	typedef struct packed {
		reg_idx_t rd;
		word_t    value;
	} result_t;

endpackage

`default_nettype wire

//--- hdl/inst_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module inst_buffer import core_pkg::*; #(
	parameter int IN_DEPTH = 4
) (
	input  wire   i_clk,
	input  wire   i_rst,
	input  wire   i_valid,
	input  inst_t i_inst,
	input  wire   i_pop,
	output inst_t o_head,
	output logic  o_not_empty,
	output logic  o_credit
);

	localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
	localparam int CNT_W = $clog2(IN_DEPTH + 1);

	inst_t            mem [IN_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// upstream pushes only while it holds a credit
	always_ff @(posedge i_clk) begin
		if (i_valid) begin
			mem[wr_ptr] <= i_inst;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (i_valid) begin
				wr_ptr <= (wr_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (i_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(i_valid) - CNT_W'(i_pop);
		end
	end

	// one credit back per entry leaving
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_credit <= 1'b0;
		end else begin
			o_credit <= i_pop;
		end
	end

	assign o_head      = mem[rd_ptr];
	assign o_not_empty = (count != '0);

endmodule

`default_nettype wire

//--- hdl/decode_unit.sv
`timescale 1ns/10ps
`default_nettype none

module decode_unit import core_pkg::*; import rv_isa_pkg::*; (
	input  wire       i_clk,
	input  wire       i_rst,
	input  wire       i_advance,
	input  inst_t     i_head,
	input  wire       i_not_empty,
	output logic      o_pop,
	output reg_idx_t  o_raddr_a,
	output reg_idx_t  o_raddr_b,
	input  word_t     i_rdata_a,
	input  word_t     i_rdata_b,
	input  exec_fwd_t i_fwd,
	output dec_uop_t  o_uop
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t      imm_i;
	word_t      imm_u;
	word_t      src_a;
	word_t      src_b;
	logic       legal;
	dec_uop_t   uop_d;
	dec_uop_t   data_q;
	logic       valid_q;

	function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
		case (f3)
			F3_ADD_SUB: alu_sel = alt ? ALU_SUB : ALU_ADD;
			F3_SLL:     alu_sel = ALU_SLL;
			F3_SLT:     alu_sel = ALU_SLT;
			F3_SLTU:    alu_sel = ALU_SLTU;
			F3_XOR:     alu_sel = ALU_XOR;
			F3_SRL_SRA: alu_sel = alt ? ALU_SRA : ALU_SRL;
			F3_OR:      alu_sel = ALU_OR;
			default:    alu_sel = ALU_AND;
		endcase
	endfunction

	assign opcode = i_head[6:0];
	assign funct3 = i_head[14:12];
	assign funct7 = i_head[31:25];
	assign imm_i  = {{20{i_head[31]}}, i_head[31:20]};
	assign imm_u  = {i_head[31:12], 12'b0};

	assign o_raddr_a = i_head[19:15];
	assign o_raddr_b = i_head[24:20];

	// execute result is not in the regfile yet
	assign src_a = (i_fwd.valid && i_fwd.rd != '0 && i_fwd.rd == o_raddr_a) ?
		i_fwd.value : i_rdata_a;
	assign src_b = (i_fwd.valid && i_fwd.rd != '0 && i_fwd.rd == o_raddr_b) ?
		i_fwd.value : i_rdata_b;

	always_comb begin
		legal        = 1'b0;
		uop_d.alu_op = ALU_ADD;
		uop_d.rd     = i_head[11:7];
		uop_d.op_a   = src_a;
		uop_d.op_b   = src_b;
		case (opcode)
			OPC_LUI: begin
				legal        = 1'b1;
				uop_d.alu_op = ALU_PASS_B;
				uop_d.op_a   = '0;
				uop_d.op_b   = imm_u;
			end
			OPC_OP: begin
				// only add/sub and srl/sra take the alternate funct7
				legal = (funct7 == 7'b0) || (funct7 == F7_ALT &&
					(funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
				uop_d.alu_op = alu_sel(funct3, funct7[5]);
			end
			OPC_OP_IMM: begin
				// shift immediates carry funct7 in the upper imm bits
				if (funct3 == F3_SLL) begin
					legal = (funct7 == 7'b0);
				end else if (funct3 == F3_SRL_SRA) begin
					legal = (funct7 == 7'b0) || (funct7 == F7_ALT);
				end else begin
					legal = 1'b1;
				end
				uop_d.alu_op = alu_sel(funct3, (funct3 == F3_SRL_SRA) && funct7[5]);
				uop_d.op_b   = imm_i;
			end
			default: begin
				legal = 1'b0;
			end
		endcase
		// illegal words are consumed as a bubble
		uop_d.valid = i_not_empty && legal;
	end

	assign o_pop = i_not_empty && i_advance;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			valid_q <= 1'b0;
		end else if (i_advance) begin
			valid_q <= uop_d.valid;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_advance) begin
			data_q <= uop_d;
		end
	end

	always_comb begin
		o_uop       = data_q;
		o_uop.valid = valid_q;
	end

endmodule

`default_nettype wire

//--- hdl/regfile.sv
`timescale 1ns/10ps
`default_nettype none

module regfile (
	input  wire         i_clk,
	input  wire         i_we,
	input  wire  [4:0]  i_waddr,
	input  wire  [31:0] i_wdata,
	input  wire  [4:0]  i_raddr_a,
	input  wire  [4:0]  i_raddr_b,
	output logic [31:0] o_rdata_a,
	output logic [31:0] o_rdata_b
);

	logic [31:0] regs [32];

	// x0 never written
	always_ff @(posedge i_clk) begin
		if (i_we && i_waddr != 5'd0) begin
			regs[i_waddr] <= i_wdata;
		end
	end

	assign o_rdata_a = (i_raddr_a == 5'd0) ? 32'd0 : regs[i_raddr_a];
	assign o_rdata_b = (i_raddr_b == 5'd0) ? 32'd0 : regs[i_raddr_b];

endmodule

`default_nettype wire

//--- hdl/alu_unit.sv
`timescale 1ns/10ps
`default_nettype none

module alu_unit import core_pkg::*; import rv_isa_pkg::*; (
	input  dec_uop_t  i_uop,
	output exec_fwd_t o_fwd
);

	word_t      a;
	word_t      b;
	logic [4:0] shamt;
	word_t      res;

	assign a     = i_uop.op_a;
	assign b     = i_uop.op_b;
	assign shamt = b[4:0];

	always_comb begin
		case (i_uop.alu_op)
			ALU_ADD: begin
				res = a + b;
			end
			ALU_SUB: begin
				res = a - b;
			end
			ALU_SLL: begin
				res = a << shamt;
			end
			ALU_SLT: begin
				res = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			end
			ALU_SLTU: begin
				res = {{(XLEN-1){1'b0}}, a < b};
			end
			ALU_XOR: begin
				res = a ^ b;
			end
			ALU_SRL: begin
				res = a >> shamt;
			end
			ALU_SRA: begin
				res = $unsigned($signed(a) >>> shamt);
			end
			ALU_OR: begin
				res = a | b;
			end
			ALU_AND: begin
				res = a & b;
			end
			// lui
			default: begin
				res = b;
			end
		endcase
	end

	assign o_fwd.valid = i_uop.valid;
	assign o_fwd.rd    = i_uop.rd;
	assign o_fwd.value = res;

endmodule

`default_nettype wire

//--- hdl/result_unit.sv
`timescale 1ns/10ps
`default_nettype none

module result_unit import core_pkg::*; #(
	parameter int RES_CREDITS = 2
) (
	input  wire       i_clk,
	input  wire       i_rst,
	input  exec_fwd_t i_fwd,
	input  wire       i_res_credit,
	output logic      o_res_valid,
	output result_t   o_res,
	output logic      o_advance,
	output logic      o_we,
	output reg_idx_t  o_waddr,
	output word_t     o_wdata
);

	localparam int CRD_W = $clog2(RES_CREDITS + 1);

	logic [CRD_W-1:0] credits_q;
	logic             full_q;
	result_t          res_q;
	logic             send;

	assign send = full_q && (credits_q != '0);

	// whole core moves only when this register can take a new entry
	assign o_advance = !full_q || send;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			full_q <= 1'b0;
		end else if (o_advance) begin
			full_q <= i_fwd.valid;
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_advance && i_fwd.valid) begin
			res_q.rd    <= i_fwd.rd;
			res_q.value <= i_fwd.value;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			credits_q <= CRD_W'(RES_CREDITS);
		end else begin
			credits_q <= credits_q - CRD_W'(send) + CRD_W'(i_res_credit);
		end
	end

	assign o_res_valid = send;
	assign o_res       = res_q;

	// architectural write at the same edge the entry is loaded
	assign o_we    = o_advance && i_fwd.valid && (i_fwd.rd != '0);
	assign o_waddr = i_fwd.rd;
	assign o_wdata = i_fwd.value;

endmodule

`default_nettype wire

//--- hdl/ex_core_top.sv
`timescale 1ns/10ps
`default_nettype none

module ex_core_top import core_pkg::*; #(
	parameter int IN_DEPTH    = IN_DEPTH_DEF,
	parameter int RES_CREDITS = RES_CREDITS_DEF
) (
	input  wire     i_clk,
	input  wire     i_rst,
	input  wire     i_inst_valid,
	input  inst_t   i_inst,
	output logic    o_inst_credit,
	output logic    o_res_valid,
	output result_t o_res,
	input  wire     i_res_credit
);

	inst_t     head;
	logic      not_empty;
	logic      pop;
	logic      advance;
	reg_idx_t  raddr_a;
	reg_idx_t  raddr_b;
	word_t     rdata_a;
	word_t     rdata_b;
	dec_uop_t  uop;
	exec_fwd_t fwd;
	logic      we;
	reg_idx_t  waddr;
	word_t     wdata;

	inst_buffer #(
		.IN_DEPTH(IN_DEPTH)
	) m_inst_buffer (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_valid    (i_inst_valid),
		.i_inst     (i_inst),
		.i_pop      (pop),
		.o_head     (head),
		.o_not_empty(not_empty),
		.o_credit   (o_inst_credit)
	);

	decode_unit m_decode (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_advance  (advance),
		.i_head     (head),
		.i_not_empty(not_empty),
		.o_pop      (pop),
		.o_raddr_a  (raddr_a),
		.o_raddr_b  (raddr_b),
		.i_rdata_a  (rdata_a),
		.i_rdata_b  (rdata_b),
		.i_fwd      (fwd),
		.o_uop      (uop)
	);

	regfile m_regfile (
		.i_clk    (i_clk),
		.i_we     (we),
		.i_waddr  (waddr),
		.i_wdata  (wdata),
		.i_raddr_a(raddr_a),
		.i_raddr_b(raddr_b),
		.o_rdata_a(rdata_a),
		.o_rdata_b(rdata_b)
	);

	alu_unit m_alu (
		.i_uop(uop),
		.o_fwd(fwd)
	);

	result_unit #(
		.RES_CREDITS(RES_CREDITS)
	) m_result (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_fwd       (fwd),
		.i_res_credit(i_res_credit),
		.o_res_valid (o_res_valid),
		.o_res       (o_res),
		.o_advance   (advance),
		.o_we        (we),
		.o_waddr     (waddr),
		.o_wdata     (wdata)
	);

endmodule

`default_nettype wire

//--- verif/ref_model.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// encoders for the RV32I base formats
function automatic inst_t enc_r(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
	input logic [2:0] f3, input reg_idx_t rd);
	return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic inst_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
	input logic [2:0] f3, input reg_idx_t rd);
	return {imm, rs1, f3, rd, OPC_OP_IMM};
endfunction

function automatic inst_t enc_u(input logic [19:0] imm, input reg_idx_t rd);
	return {imm, rd, OPC_LUI};
endfunction

// logical shift plus a mask of copied sign bits
function automatic word_t sra_ref(input word_t a, input logic [4:0] sh);
	word_t fill;
	fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
	return (a >> sh) | fill;
endfunction

// OP and OP-IMM result, b is rs2 or the sign-extended immediate
function automatic word_t isa_result(input logic [2:0] f3, input logic alt,
	input word_t a, input word_t b);
	word_t r;
	case (f3)
		F3_ADD_SUB: r = alt ? a - b : a + b;
		F3_SLL:     r = a << b[4:0];
		F3_SLT:     r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		F3_SLTU:    r = (a < b) ? 32'd1 : 32'd0;
		F3_XOR:     r = a ^ b;
		F3_SRL_SRA: r = alt ? sra_ref(a, b[4:0]) : a >> b[4:0];
		F3_OR:      r = a | b;
		default:    r = a & b;
	endcase
	return r;
endfunction

`endif

//--- verif/tb_ex_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ex_core import core_pkg::*; import rv_isa_pkg::*; ();

	localparam int IN_DEPTH     = 4;
	localparam int RES_CREDITS  = 2;
	localparam int N_INSTR      = 129;
	localparam int WATCHDOG_CYC = 16 + 20 * N_INSTR;

	// the ten R-type operations
	localparam logic [2:0] OP_F3 [10] = '{F3_ADD_SUB, F3_ADD_SUB, F3_SLL, F3_SLT, F3_SLTU,
		F3_XOR, F3_SRL_SRA, F3_SRL_SRA, F3_OR, F3_AND};
	localparam logic OP_ALT [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};

	logic    i_clk;
	logic    i_rst;
	logic    i_inst_valid;
	inst_t   i_inst;
	logic    o_inst_credit;
	logic    o_res_valid;
	result_t o_res;
	logic    i_res_credit;

	integer  seed = 32'h590b;
	word_t   ref_regs [32];
	result_t exp_q [$];
	int      acc_q [$];
	logic    drv_legal;
	logic    withhold;
	logic    chk_latency;
	string   cur_test = "reset";
	int      cyc = 0;
	int      in_outstanding = 0;
	int      out_avail = RES_CREDITS;
	int      pending_ret = 0;
	logic    rst_q = 1'b0;
	int      mon_errors = 0;
	int      main_errors = 0;
	int      err_mark = 0;
	int      tests_run = 0;
	int      tests_failed = 0;

	`include "ref_model.svh"

	ex_core_top #(
		.IN_DEPTH   (IN_DEPTH),
		.RES_CREDITS(RES_CREDITS)
	) i_dut (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_inst_valid (i_inst_valid),
		.i_inst       (i_inst),
		.o_inst_credit(o_inst_credit),
		.o_res_valid  (o_res_valid),
		.o_res        (o_res),
		.i_res_credit (i_res_credit)
	);

	initial begin : clock_gen
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	function automatic logic [31:0] rnd();
		return $random(seed);
	endfunction

	// x1..x15 when nz otherwise x0..x15
	function automatic reg_idx_t pick_reg(input logic nz);
		int lo;
		lo = nz ? 1 : 0;
		return reg_idx_t'(lo + int'(rnd() % 32'(16 - lo)));
	endfunction

	// sampled at the edge, before the DUT registers move
	always @(posedge i_clk) begin : monitor
		result_t want;
		int      lat;
		cyc = cyc + 1;
		// state is unknown before the first reset edge
		if (rst_q) begin
			assert (!o_res_valid && !o_inst_credit) else begin
				mon_errors++;
				$display("ERROR %s: outputs active during or just after reset", cur_test);
			end
		end
		rst_q = i_rst;
		if (!i_rst) begin
			if (i_inst_valid) begin
				in_outstanding++;
				if (drv_legal) begin
					acc_q.push_back(cyc);
				end
			end
			if (o_inst_credit) begin
				in_outstanding--;
			end
			assert (in_outstanding >= 0) else begin
				mon_errors++;
				$display("ERROR %s: input credit returned with none outstanding", cur_test);
			end
			if (o_res_valid) begin
				assert (out_avail > 0) else begin
					mon_errors++;
					$display("ERROR %s: result sent with no output credit left", cur_test);
				end
				out_avail--;
				pending_ret++;
				assert (exp_q.size() != 0) else begin
					mon_errors++;
					$display("ERROR %s: result sent with none expected", cur_test);
				end
				if (exp_q.size() != 0) begin
					want = exp_q.pop_front();
					lat  = cyc - acc_q.pop_front();
					assert (o_res == want) else begin
						mon_errors++;
						$display("MISMATCH %s: expected rd %0d value %h, actual rd %0d value %h",
							cur_test, want.rd, want.value, o_res.rd, o_res.value);
					end
					assert (!chk_latency || lat == 3) else begin
						mon_errors++;
						$display("MISMATCH %s: expected latency 3, actual latency %0d",
							cur_test, lat);
					end
				end
			end
			if (i_res_credit) begin
				out_avail++;
				pending_ret--;
			end
		end
	end

	// one credit back per cycle unless withheld
	initial begin : credit_return
		i_res_credit = 1'b0;
		forever begin
			@(posedge i_clk);
			#1;
			i_res_credit = (pending_ret > 0) && !(withhold && ((cyc / 12) % 3 != 2));
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYC) @(posedge i_clk);
		$display("ERROR: run did not finish within %0d cycles", WATCHDOG_CYC);
		$display("Testbench failed");
		$finish;
	end

	// waits for an input credit and holds valid for one edge
	task automatic issue(input inst_t inst, input logic legal, input reg_idx_t rd,
		input word_t v);
		while (in_outstanding >= IN_DEPTH) begin
			i_inst_valid = 1'b0;
			@(posedge i_clk);
			#1;
		end
		i_inst_valid = 1'b1;
		i_inst       = inst;
		drv_legal    = legal;
		if (legal) begin
			exp_q.push_back({rd, v});
			if (rd != '0) begin
				ref_regs[rd] = v;
			end
		end
		@(posedge i_clk);
		#1;
		i_inst_valid = 1'b0;
	endtask

	task automatic do_r(input logic [2:0] f3, input logic alt, input reg_idx_t rd,
		input reg_idx_t rs1, input reg_idx_t rs2);
		word_t v;
		v = isa_result(f3, alt, ref_regs[rs1], ref_regs[rs2]);
		issue(enc_r(alt ? F7_ALT : 7'b0, rs2, rs1, f3, rd), 1'b1, rd, v);
	endtask

	task automatic do_i(input logic [2:0] f3, input logic [11:0] imm, input reg_idx_t rd,
		input reg_idx_t rs1);
		logic  alt;
		word_t v;
		alt = (f3 == F3_SRL_SRA) && imm[10];
		v   = isa_result(f3, alt, ref_regs[rs1], {{20{imm[11]}}, imm});
		issue(enc_i(imm, rs1, f3, rd), 1'b1, rd, v);
	endtask

	task automatic do_lui(input logic [19:0] imm, input reg_idx_t rd);
		issue(enc_u(imm, rd), 1'b1, rd, {imm, 12'b0});
	endtask

	task automatic rand_r(input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
		int k;
		k = int'(rnd() % 10);
		do_r(OP_F3[k], OP_ALT[k], rd, rs1, rs2);
	endtask

	// mostly OP-IMM with some LUI and legal shift fields
	task automatic rand_imm(input reg_idx_t rs1, input reg_idx_t rd);
		logic [31:0] r;
		logic [11:0] imm;
		r   = rnd();
		imm = r[31:20];
		if (r[5:3] == 3'd0) begin
			do_lui(r[31:12], rd);
		end else begin
			if (r[2:0] == F3_SLL) begin
				imm = {7'b0, imm[4:0]};
			end else if (r[2:0] == F3_SRL_SRA) begin
				imm = {r[8] ? F7_ALT : 7'b0, imm[4:0]};
			end
			do_i(r[2:0], imm, rd, rs1);
		end
	endtask

	task automatic drain();
		int n;
		n = 0;
		while ((exp_q.size() != 0 || pending_ret != 0 || in_outstanding != 0) && n < 200) begin
			@(posedge i_clk);
			#1;
			n++;
		end
		if (n >= 200) begin
			main_errors++;
			$display("ERROR %s: pipeline did not drain, %0d results and %0d input credits out",
				cur_test, exp_q.size(), in_outstanding);
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		err_mark = mon_errors + main_errors;
	endtask

	task automatic finish_test();
		int e;
		e = mon_errors + main_errors - err_mark;
		tests_run++;
		if (e == 0) begin
			$display("test %s: ok", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", cur_test, e);
		end
	endtask

	initial begin : main
		int          k;
		reg_idx_t    rd;
		reg_idx_t    prev;
		logic [31:0] r;
		i_rst        = 1'b1;
		i_inst_valid = 1'b0;
		i_inst       = '0;
		drv_legal    = 1'b0;
		withhold     = 1'b0;
		chk_latency  = 1'b0;
		for (k = 0; k < 32; k++) begin
			ref_regs[k] = '0;
		end

		start_test("reset");
		repeat (16) @(posedge i_clk);
		#1;
		i_rst = 1'b0;
		@(posedge i_clk);
		#1;
		finish_test();

		start_test("r_type");
		for (k = 1; k < 16; k++) begin
			r = rnd();
			do_lui(r[31:12], reg_idx_t'(k));
			do_i(F3_ADD_SUB, r[11:0], reg_idx_t'(k), reg_idx_t'(k));
		end
		for (k = 0; k < 20; k++) begin
			do_r(OP_F3[k % 10], OP_ALT[k % 10], pick_reg(1'b1), pick_reg(1'b0), pick_reg(1'b0));
		end
		drain();
		finish_test();

		// each one reads the rd of the one before
		start_test("imm_bypass");
		prev = pick_reg(1'b1);
		for (k = 0; k < 24; k++) begin
			rd = pick_reg(1'b1);
			rand_imm(prev, rd);
			prev = rd;
		end
		drain();
		finish_test();

		start_test("x0_illegal");
		do_i(F3_ADD_SUB, 12'd123, 5'd0, 5'd5);
		issue(32'h0000_2083, 1'b0, 5'd0, '0);
		do_r(F3_ADD_SUB, 1'b0, 5'd0, 5'd1, 5'd2);
		// x0 read right behind an x0 write
		do_r(F3_ADD_SUB, 1'b0, 5'd1, 5'd0, 5'd0);
		issue(enc_r(7'b0000001, 5'd2, 5'd1, F3_ADD_SUB, 5'd3), 1'b0, 5'd0, '0);
		issue(enc_i(12'h401, 5'd1, F3_SLL, 5'd4), 1'b0, 5'd0, '0);
		do_i(F3_OR, 12'h5a5, 5'd2, 5'd0);
		// rs2 taken from the write just ahead
		do_r(F3_OR, 1'b0, 5'd3, 5'd0, 5'd2);
		issue(enc_r(F7_ALT, 5'd2, 5'd1, F3_XOR, 5'd6), 1'b0, 5'd0, '0);
		drain();
		finish_test();

		start_test("backpressure");
		withhold = 1'b1;
		for (k = 0; k < 30; k++) begin
			r = rnd();
			if (r[0]) begin
				rand_r(pick_reg(1'b1), pick_reg(1'b0), pick_reg(1'b0));
			end else begin
				rand_imm(pick_reg(1'b0), pick_reg(1'b1));
			end
		end
		withhold = 1'b0;
		drain();
		finish_test();

		start_test("throughput");
		chk_latency = 1'b1;
		for (k = 0; k < 16; k++) begin
			rand_r(pick_reg(1'b1), pick_reg(1'b0), pick_reg(1'b0));
		end
		drain();
		chk_latency = 1'b0;
		finish_test();

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed,
			mon_errors + main_errors);
		if (tests_failed == 0 && mon_errors + main_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+verif
hdl/rv_isa_pkg.sv
hdl/core_pkg.sv
hdl/inst_buffer.sv
hdl/decode_unit.sv
hdl/regfile.sv
hdl/alu_unit.sv
hdl/result_unit.sv
hdl/ex_core_top.sv
verif/tb_ex_core.sv

//--- Makefile
TOP := tb_ex_core

.PHONY: all lint clean

all:
	verilator --binary --timing -f tb.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir
